// ==== common/pulse_bank_settings.svh ====
//----------------------------------------------------------------------
// build-time sizes of the pulse bank
// channel count and phase counter width
//----------------------------------------------------------------------

`ifndef PULSE_BANK_SETTINGS_SVH
`define PULSE_BANK_SETTINGS_SVH

// number of independent pulse channels in the bank
`define PB_CHANNELS 4

// width of the low/high settings and of the phase down-counters
`define PB_WIDTH_BITS 16

`endif

// ==== common/pulse_bank_pkg.sv ====
//----------------------------------------------------------------------
// shared types of the pulse bank
// widths, channel index, masks, command codes, channel states
//----------------------------------------------------------------------

`include "pulse_bank_settings.svh"

package pulse_bank_pkg;

	typedef logic [`PB_WIDTH_BITS-1:0] width_t;           // phase length in clocks
	typedef logic [$clog2(`PB_CHANNELS)-1:0] chan_t;      // channel index
	typedef logic [`PB_CHANNELS-1:0] mask_t;              // one bit per channel

	// command codes on cmd_op
	typedef enum logic [1:0] {
		OP_NOP   = 2'd0,                                  // nothing
		OP_WRITE = 2'd1,                                  // stage low/high/rpt for cmd_chan
		OP_FIRE  = 2'd2,                                  // start channels in cmd_mask
		OP_STOP  = 2'd3                                   // stop channels in cmd_mask
	} cmd_op_t;

	// channel FSM
	typedef enum logic [1:0] {
		PG_IDLE = 2'd0,                                   // waiting for start
		PG_LOW  = 2'd1,                                   // out held low
		PG_HIGH = 2'd2                                    // out held high
	} pg_state_t;

endpackage

// ==== pulse_gen/pulse_gen.sv ====
//----------------------------------------------------------------------
// single pulse channel
// latches widths and repeat flag on start, runs low then high phase
//----------------------------------------------------------------------

`timescale 1ns/100ps

module pulse_gen import pulse_bank_pkg::*; (
	input  logic   clk,
	input  logic   nrst,
	input  logic   start,                             // one-cycle start strobe
	input  logic   stop,                              // one-cycle stop strobe
	input  width_t low_wdth,                          // staged low width
	input  width_t high_wdth,                         // staged high width
	input  logic   rpt,                               // staged repeat flag
	output logic   busy,
	output logic   out
);

	localparam width_t WDTH_ONE = width_t'(1);

	pg_state_t state;
	pg_state_t state_nxt;
	width_t    cnt;                                   // cycles left in phase, minus one
	width_t    cnt_nxt;
	width_t    max_low;                               // latched low width
	width_t    max_high;                              // latched high width
	logic      rpt_buf;                               // latched repeat flag
	width_t    start_low;
	width_t    start_high;
	logic      latch_en;

	// zero width runs as one cycle
	assign start_low  = (low_wdth == '0) ? WDTH_ONE : low_wdth;
	assign start_high = (high_wdth == '0) ? WDTH_ONE : high_wdth;

	// start only counts while idle, stop wins
	assign latch_en = (state == PG_IDLE) && start && !stop;

	//----------------------------------------------------------------------
	// next state and counter
	//----------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		cnt_nxt   = cnt;
		if (stop) begin
			state_nxt = PG_IDLE;                          // forced off by command
		end else begin
			case (state)
				PG_IDLE: begin
					if (start) begin
						state_nxt = PG_LOW;
						cnt_nxt   = start_low - WDTH_ONE;
					end
				end
				PG_LOW: begin
					if (cnt == '0) begin
						state_nxt = PG_HIGH;
						cnt_nxt   = max_high - WDTH_ONE;
					end else begin
						cnt_nxt = cnt - WDTH_ONE;
					end
				end
				PG_HIGH: begin
					if (cnt == '0) begin
						if (rpt_buf) begin
							state_nxt = PG_LOW;               // next period right away
							cnt_nxt   = max_low - WDTH_ONE;
						end else begin
							state_nxt = PG_IDLE;              // one-shot done
						end
					end else begin
						cnt_nxt = cnt - WDTH_ONE;
					end
				end
				default: state_nxt = PG_IDLE;
			endcase
		end
	end

	//----------------------------------------------------------------------
	// state, counter and outputs
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nrst) begin
			state   <= PG_IDLE;
			cnt     <= '0;
			rpt_buf <= 1'b0;
			busy    <= 1'b0;
			out     <= 1'b0;
		end else begin
			state <= state_nxt;
			cnt   <= cnt_nxt;
			busy  <= (state_nxt != PG_IDLE);              // same edge as state
			out   <= (state_nxt == PG_HIGH);
			if (latch_en) begin
				rpt_buf <= rpt;
			end
		end
	end

	// widths held for the whole run
	always_ff @(posedge clk) begin
		if (latch_en) begin
			max_low  <= start_low;
			max_high <= start_high;
		end
	end

endmodule

// ==== src/pulse_cmd_regs.sv ====
//----------------------------------------------------------------------
// command decoder and per-channel staging registers
// turns fire/stop commands into one-cycle mask strobes
//----------------------------------------------------------------------

`timescale 1ns/100ps

`include "pulse_bank_settings.svh"

module pulse_cmd_regs import pulse_bank_pkg::*; (
	input  logic     clk,
	input  logic     nrst,
	// command port
	input  logic     cmd_valid,                       // single-cycle strobe
	input  cmd_op_t  cmd_op,
	input  chan_t    cmd_chan,                        // target of a write
	input  mask_t    cmd_mask,                        // targets of fire/stop
	input  width_t   cmd_low,
	input  width_t   cmd_high,
	input  logic     cmd_rpt,
	// to the channels
	output mask_t    start_stb,
	output mask_t    stop_stb,
	output width_t   low_wdth [`PB_CHANNELS],
	output width_t   high_wdth [`PB_CHANNELS],
	output mask_t    rpt
);

	localparam width_t WDTH_RST = width_t'(1);        // staged width after reset

	logic wr_en;
	logic fire_en;
	logic stop_en;

	//----------------------------------------------------------------------
	// decode
	//----------------------------------------------------------------------
	assign wr_en   = cmd_valid && (cmd_op == OP_WRITE);
	assign fire_en = cmd_valid && (cmd_op == OP_FIRE);
	assign stop_en = cmd_valid && (cmd_op == OP_STOP);

	//----------------------------------------------------------------------
	// strobes
	//----------------------------------------------------------------------
	// one cycle wide, then back to zero
	always_ff @(posedge clk) begin
		if (!nrst) begin
			start_stb <= '0;
			stop_stb  <= '0;
		end else begin
			start_stb <= fire_en ? cmd_mask : '0;
			stop_stb  <= stop_en ? cmd_mask : '0;
		end
	end

	//----------------------------------------------------------------------
	// staging registers
	//----------------------------------------------------------------------
	// a fire in the cycle after a write already sees the new values
	always_ff @(posedge clk) begin
		if (!nrst) begin
			for (int i = 0; i < `PB_CHANNELS; i++) begin
				low_wdth[i]  <= WDTH_RST;
				high_wdth[i] <= WDTH_RST;
				rpt[i]       <= 1'b0;
			end
		end else begin
			for (int i = 0; i < `PB_CHANNELS; i++) begin
				if (wr_en && (cmd_chan == chan_t'(i))) begin  // addressed channel only
					low_wdth[i]  <= cmd_low;
					high_wdth[i] <= cmd_high;
					rpt[i]       <= cmd_rpt;
				end
			end
		end
	end

endmodule

// ==== src/pulse_bank_top.sv ====
//----------------------------------------------------------------------
// pulse bank top level
// command decoder plus one pulse_gen per channel
//----------------------------------------------------------------------

`timescale 1ns/100ps

`include "pulse_bank_settings.svh"

module pulse_bank_top import pulse_bank_pkg::*; (
	input  logic    clk,
	input  logic    nrst,
	input  logic    cmd_valid,
	input  cmd_op_t cmd_op,
	input  chan_t   cmd_chan,
	input  mask_t   cmd_mask,
	input  width_t  cmd_low,
	input  width_t  cmd_high,
	input  logic    cmd_rpt,
	output mask_t   busy,                             // per channel
	output mask_t   out                               // per channel
);

	mask_t  start_stb;
	mask_t  stop_stb;
	width_t low_wdth [`PB_CHANNELS];
	width_t high_wdth [`PB_CHANNELS];
	mask_t  rpt;

	pulse_cmd_regs pulse_cmd_regs_i (
		.clk       (clk),
		.nrst      (nrst),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_chan  (cmd_chan),
		.cmd_mask  (cmd_mask),
		.cmd_low   (cmd_low),
		.cmd_high  (cmd_high),
		.cmd_rpt   (cmd_rpt),
		.start_stb (start_stb),
		.stop_stb  (stop_stb),
		.low_wdth  (low_wdth),
		.high_wdth (high_wdth),
		.rpt       (rpt)
	);

	// channels
	for (genvar i = 0; i < `PB_CHANNELS; i++) begin : g_chan
		pulse_gen pulse_gen_i (
			.clk       (clk),
			.nrst      (nrst),
			.start     (start_stb[i]),
			.stop      (stop_stb[i]),
			.low_wdth  (low_wdth[i]),
			.high_wdth (high_wdth[i]),
			.rpt       (rpt[i]),
			.busy      (busy[i]),
			.out       (out[i])
		);
	end

endmodule

// ==== testbench/pulse_bank_tb.sv ====
//----------------------------------------------------------------------
// testbench for the pulse bank
// file-driven commands and checks, per-cycle reference model
//----------------------------------------------------------------------

`timescale 1ns/100ps

`include "pulse_bank_settings.svh"

module pulse_bank_tb import pulse_bank_pkg::*; ();

	localparam int NCH     = `PB_CHANNELS;
	localparam int MAX_REC = 128;                    // record storage depth

	// DUT ports
	logic    clk = 1'b0;
	logic    nrst;
	logic    cmd_valid;
	cmd_op_t cmd_op;
	chan_t   cmd_chan;
	mask_t   cmd_mask;
	width_t  cmd_low;
	width_t  cmd_high;
	logic    cmd_rpt;
	mask_t   busy;
	mask_t   out;

	// records read from the stimulus file
	logic [7:0]  rec_kind [MAX_REC];                 // "C" command or "K" check
	logic [31:0] rec_wait [MAX_REC];                 // edges to advance first
	logic [31:0] rec_val [MAX_REC][6];               // record fields after the wait
	int          rec_cnt;
	logic        file_ok;

	// error counters
	int cycle_mism_cnt = 0;                          // per-cycle model compare
	int check_mism_cnt = 0;                          // check records
	int other_cnt      = 0;                          // file problems
	int timeout_cnt    = 0;
	int cycle_cnt      = 0;
	int cycle_limit    = 1000000;                    // replaced once the file is read

	// reference model state
	mask_t       m_start_pipe;                       // start strobe in this cycle
	mask_t       m_stop_pipe;                        // stop strobe in this cycle
	width_t      m_stg_low [NCH];
	width_t      m_stg_high [NCH];
	logic        m_stg_rpt [NCH];
	pg_state_t   m_state [NCH];                      // phase of each channel
	int unsigned m_pos [NCH];                        // cycle index inside the period
	int unsigned m_lat_low [NCH];
	int unsigned m_lat_high [NCH];
	logic        m_lat_rpt [NCH];
	mask_t       exp_busy;
	mask_t       exp_out;
	logic        model_ready = 1'b0;

	pulse_bank_top pulse_bank_top_i (
		.clk       (clk),
		.nrst      (nrst),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_chan  (cmd_chan),
		.cmd_mask  (cmd_mask),
		.cmd_low   (cmd_low),
		.cmd_high  (cmd_high),
		.cmd_rpt   (cmd_rpt),
		.busy      (busy),
		.out       (out)
	);

	always #50 clk = ~clk;                           // 100 ns period

	// a zero width counts as one cycle
	function automatic int unsigned phase_len(input width_t w);
		int unsigned len;
		if (w == '0) begin
			len = 1;
		end else begin
			len = 32'(w);
		end
		return len;
	endfunction

	//----------------------------------------------------------------------
	// reference model, one step per rising edge
	//----------------------------------------------------------------------
	always @(posedge clk) begin
		if (!nrst) begin
			m_start_pipe = '0;
			m_stop_pipe  = '0;
			for (int c = 0; c < NCH; c++) begin
				m_stg_low[c]  = width_t'(1);             // staged widths after reset
				m_stg_high[c] = width_t'(1);
				m_stg_rpt[c]  = 1'b0;
				m_state[c]    = PG_IDLE;
				m_pos[c]      = 0;
				m_lat_low[c]  = 1;
				m_lat_high[c] = 1;
				m_lat_rpt[c]  = 1'b0;
			end
			model_ready = 1'b1;
		end else begin
			for (int c = 0; c < NCH; c++) begin
				if (m_stop_pipe[c]) begin
					m_state[c] = PG_IDLE;                  // stopped by command
				end else if (m_state[c] != PG_IDLE) begin
					m_pos[c]++;
					if (m_pos[c] == m_lat_low[c] + m_lat_high[c]) begin
						m_pos[c]   = 0;                      // period done
						m_state[c] = m_lat_rpt[c] ? PG_LOW : PG_IDLE;
					end else if (m_pos[c] >= m_lat_low[c]) begin
						m_state[c] = PG_HIGH;
					end
				end else if (m_start_pipe[c]) begin
					m_state[c]    = PG_LOW;                // idle channel takes the start
					m_pos[c]      = 0;
					m_lat_low[c]  = phase_len(m_stg_low[c]);
					m_lat_high[c] = phase_len(m_stg_high[c]);
					m_lat_rpt[c]  = m_stg_rpt[c];
				end
			end
			// command of the cycle that just ended
			m_start_pipe = (cmd_valid && cmd_op == OP_FIRE) ? cmd_mask : '0;
			m_stop_pipe  = (cmd_valid && cmd_op == OP_STOP) ? cmd_mask : '0;
			if (cmd_valid && cmd_op == OP_WRITE) begin
				m_stg_low[cmd_chan]  = cmd_low;
				m_stg_high[cmd_chan] = cmd_high;
				m_stg_rpt[cmd_chan]  = cmd_rpt;
			end
		end
		for (int c = 0; c < NCH; c++) begin
			exp_busy[c] = (m_state[c] != PG_IDLE);
			exp_out[c]  = (m_state[c] == PG_HIGH);
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (model_ready && nrst) begin
			assert (busy === exp_busy) else begin
				$display("mismatch busy at cycle %0d: expected %h, got %h",
					cycle_cnt, exp_busy, busy);
				cycle_mism_cnt++;
			end
			assert (out === exp_out) else begin
				$display("mismatch out at cycle %0d: expected %h, got %h",
					cycle_cnt, exp_out, out);
				cycle_mism_cnt++;
			end
		end
	end

	task automatic print_error_counts();
		$display("errors: cycle %0d, check %0d, file %0d, timeout %0d",
			cycle_mism_cnt, check_mism_cnt, other_cnt, timeout_cnt);
	endtask

	//----------------------------------------------------------------------
	// timeout
	//----------------------------------------------------------------------
	always @(posedge clk) begin
		cycle_cnt++;
		assert (cycle_cnt <= cycle_limit) else begin
			$display("error: the run timed out after %0d cycles", cycle_cnt);
			timeout_cnt++;
			print_error_counts();
			$display("** FAIL **");
			$finish;
		end
	end

	//----------------------------------------------------------------------
	// stimulus file
	//----------------------------------------------------------------------
	task automatic load_records();
		int              fd;
		int              n;
		int              wait_sum;
		logic            done;
		logic [8*16-1:0] kind;
		logic [8*256-1:0] skip;
		logic [31:0]     v [7];
		done     = 1'b0;
		wait_sum = 0;
		rec_cnt  = 0;
		file_ok  = 1'b1;
		fd = $fopen("testbench/pulse_bank_input.txt", "r");
		assert (fd != 0) else begin
			$display("error: the stimulus file could not be opened");
			other_cnt++;
			file_ok = 1'b0;
			done    = 1'b1;
		end
		while (!done) begin
			kind = '0;
			n = $fscanf(fd, "%s", kind);
			assert (n == 1) else begin
				$display("error: the stimulus file ends before its end marker");
				other_cnt++;
				file_ok = 1'b0;
				done    = 1'b1;
			end
			if (n == 1) begin
				if (kind == "#") begin
					n = $fgets(skip, fd);                  // rest of a comment line
				end else if (kind == "E") begin
					done = 1'b1;
				end else if (kind == "C" || kind == "K") begin
					if (kind == "C") begin
						n = $fscanf(fd, "%h %h %h %h %h %h %h",
							v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
					end else begin
						n = $fscanf(fd, "%h %h %h", v[0], v[1], v[2]);
						n = (n == 3) ? 7 : n;
						v[3] = '0;
						v[4] = '0;
						v[5] = '0;
						v[6] = '0;
					end
					assert (n == 7 && rec_cnt < MAX_REC) else begin
						$display("error: record %0d in the stimulus file is malformed",
							rec_cnt);
						other_cnt++;
						file_ok = 1'b0;
						done    = 1'b1;
					end
					if (file_ok) begin
						rec_kind[rec_cnt] = kind[7:0];
						rec_wait[rec_cnt] = v[0];
						for (int k = 0; k < 6; k++) begin
							rec_val[rec_cnt][k] = v[k+1];
						end
						wait_sum += int'(v[0]);
						rec_cnt++;
					end
				end else begin
					assert (1'b0) else begin
						$display("error: unknown record kind in the stimulus file");
						other_cnt++;
						file_ok = 1'b0;
						done    = 1'b1;
					end
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		cycle_limit = wait_sum + 200;
	endtask

	// ends 1 ns after the last edge
	task automatic wait_edges(input int cnt);
		repeat (cnt) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic drive_command(input int idx);
		wait_edges(int'(rec_wait[idx]));
		cmd_op    = cmd_op_t'(rec_val[idx][0][1:0]);
		cmd_chan  = chan_t'(rec_val[idx][1]);
		cmd_mask  = mask_t'(rec_val[idx][2]);
		cmd_low   = width_t'(rec_val[idx][3]);
		cmd_high  = width_t'(rec_val[idx][4]);
		cmd_rpt   = rec_val[idx][5][0];
		cmd_valid = 1'b1;                              // one-cycle strobe
		wait_edges(1);
		cmd_valid = 1'b0;
		cmd_op    = OP_NOP;
	endtask

	task automatic compare_check(input int idx);
		mask_t want_busy;
		mask_t want_out;
		wait_edges(int'(rec_wait[idx]));
		want_busy = mask_t'(rec_val[idx][0]);
		want_out  = mask_t'(rec_val[idx][1]);
		assert (busy === want_busy) else begin
			$display("mismatch busy at check record %0d: expected %h, got %h",
				idx, want_busy, busy);
			check_mism_cnt++;
		end
		assert (out === want_out) else begin
			$display("mismatch out at check record %0d: expected %h, got %h",
				idx, want_out, out);
			check_mism_cnt++;
		end
	endtask

	//----------------------------------------------------------------------
	// main sequence
	//----------------------------------------------------------------------
	initial begin
		nrst      = 1'b0;
		cmd_valid = 1'b0;
		cmd_op    = OP_NOP;
		cmd_chan  = '0;
		cmd_mask  = '0;
		cmd_low   = '0;
		cmd_high  = '0;
		cmd_rpt   = 1'b0;
		load_records();
		repeat (4) @(posedge clk);                     // reset for 4 cycles
		#1;
		nrst = 1'b1;
		if (file_ok) begin
			for (int i = 0; i < rec_cnt; i++) begin
				if (rec_kind[i] == "C") begin
					drive_command(i);
				end else begin
					compare_check(i);
				end
			end
		end
		wait_edges(4);                                 // last cycles through the model
		print_error_counts();
		if (cycle_mism_cnt == 0 && check_mism_cnt == 0 && other_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== testbench/pulse_bank_input.txt ====
# C wait op chan mask low high rpt : command, all hex, wait in edges before it
# K wait busy out : expected outputs in the cycle reached after the wait, E ends
# reset values, then a fire with no write on channel 1
K 0 0 0
C 0 2 0 2 0 0 0
K 1 2 0
K 1 2 2
K 1 0 0
# one-shot on channel 0, low 3 high 5
C 0 1 0 0 3 5 0
C 1 2 0 1 0 0 0
K 0 0 0
K 1 1 0
K 2 1 0
K 1 1 1
K 4 1 1
K 1 0 0
# channel 2 repeating, low 2 high 4, then stopped
C 0 1 2 0 2 4 1
C 0 2 0 4 0 0 0
K 1 4 0
K 2 4 4
K 3 4 4
K 1 4 0
K 2 4 4
K 4 4 0
K 2 4 4
C 0 3 0 4 0 0 0
K 0 4 4
K 1 0 0
# channel 3 fired again while busy, new widths only on the next run
C 0 1 3 0 2 3 0
C 0 2 0 8 0 0 0
C 0 1 3 0 6 1 0
C 0 2 0 8 0 0 0
K 0 8 0
K 1 8 8
K 2 8 8
K 1 0 0
C 0 2 0 8 0 0 0
K 1 8 0
K 5 8 0
K 1 8 8
K 1 0 0
# mask fire 1011 with zero widths on channels 0 and 1
C 0 1 0 0 0 2 0
C 0 1 1 0 2 0 0
C 0 1 3 0 3 1 0
C 0 2 0 b 0 0 0
K 1 b 0
K 1 b 1
K 1 b 3
K 1 8 8
K 1 0 0
# write then fire in the next cycle on channel 1
C 0 1 1 0 4 2 0
C 0 2 0 2 0 0 0
K 1 2 0
K 3 2 0
K 1 2 2
K 1 2 2
K 1 0 0
# nop, then a short repeating run on channel 2 cut off by a stop
C 0 0 0 0 0 0 0
C 2 2 0 4 0 0 0
C 1 3 0 c 0 0 0
K 0 4 0
K 1 0 0
K a 0 0
E

// ==== pulse_bank.f ====
+incdir+common
common/pulse_bank_pkg.sv
pulse_gen/pulse_gen.sv
src/pulse_cmd_regs.sv
src/pulse_bank_top.sv
testbench/pulse_bank_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pulse bank testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module pulse_bank_tb \
	-f pulse_bank.f \
	--Mdir obj_dir \
	-o pulse_bank_sim

./obj_dir/pulse_bank_sim > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi

echo "simulation passed"
exit 0
